// ==== bench/program.hex ====
// One 32-bit instruction word per line in address order from 0x00
// Columns: instruction word in hex, then byte address and assembly
3C011234 // 00: lui   r1, 0x1234
34215678 // 04: ori   r1, r1, 0x5678
24020040 // 08: addiu r2, r0, 0x40
00221821 // 0c: addu  r3, r1, r2
00612023 // 10: subu  r4, r3, r1
8C450000 // 14: lw    r5, 0(r2)
00A13026 // 18: xor   r6, r5, r1
AC460004 // 1c: sw    r6, 4(r2)
8C470004 // 20: lw    r7, 4(r2)
10E60002 // 24: beq   r7, r6, 0x30
00074100 // 28: sll   r8, r7, 4
24097777 // 2c: addiu r9, r0, 0x7777
00A1502A // 30: slt   r10, r5, r1
154A0005 // 34: bne   r10, r10, 0x4c
00A65824 // 38: and   r11, r5, r6
01636025 // 3c: or    r12, r11, r3
AC4CFFF8 // 40: sw    r12, -8(r2)
8C4DFFF8 // 44: lw    r13, -8(r2)
15A00003 // 48: bne   r13, r0, 0x58
25AE0001 // 4c: addiu r14, r13, 1
240F0001 // 50: addiu r15, r0, 1
240F0002 // 54: addiu r15, r0, 2
08000019 // 58: j     0x64
01CD8021 // 5c: addu  r16, r14, r13
24110003 // 60: addiu r17, r0, 3
AC500008 // 64: sw    r16, 8(r2)
10010004 // 68: beq   r0, r1, 0x7c
24000005 // 6c: addiu r0, r0, 5
8C520008 // 70: lw    r18, 8(r2)
02529821 // 74: addu  r19, r18, r18
0800001E // 78: j     0x78
00000000 // 7c: nop

// ==== all.f ====
hdl/cpu_pkg.sv
hdl/regs.sv
hdl/ctrl.sv
hdl/cpu_if.sv
hdl/cpu_id.sv
hdl/cpu_ex.sv
hdl/cpu_mem.sv
hdl/trivial_mips.sv
bench/retire_checker.sv
bench/tb_trivial_mips.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	-f all.f --top-module tb_trivial_mips \
	-Mdir obj_dir -o sim_trivial_mips

./obj_dir/sim_trivial_mips | tee sim.log

if grep -qx "TEST OK" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

// ==== bench/tb_trivial_mips.sv ====
`default_nettype none

module tb_trivial_mips
	import cpu_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 8;
	localparam int PROG_WORDS   = 32;
	// Budget per program word covers data stalls
	localparam int WATCHDOG_NS  = (RESET_CYCLES + 16 * PROG_WORDS) * CLK_PERIOD;

	logic          clk = 1'b0;
	logic          rst_n;
	InstAddr_t     inst_addr;
	Inst_t         inst;
	MemAccessReq_t data_req;
	Word_t         data_rdata;
	logic          data_stall;
	RetireInfo_t   retire;

	Word_t       imem [64];
	Word_t       dmem [64];
	Word_t       data_init [64];
	int          errors;
	int          retired;
	logic        loop_done;

	always #(CLK_PERIOD / 2) clk = ~clk;

	trivial_mips #(
		.REG_FORWARD(1)
	) DUT (
		.clk(clk),
		.rst_n_i(rst_n),
		.inst_addr_o(inst_addr),
		.inst_i(inst),
		.data_req_o(data_req),
		.data_rdata_i(data_rdata),
		.data_stall_i(data_stall),
		.retire_o(retire)
	);

	retire_checker scoreboard (
		.clk(clk),
		.rst_n_i(rst_n),
		.retire_i(retire),
		.data_req_i(data_req),
		.data_stall_i(data_stall),
		.data_init_i(data_init),
		.errors_o(errors),
		.retired_o(retired),
		.done_o(loop_done)
	);

	// Both memories answer in the same cycle
	assign inst       = imem[inst_addr[7:2]];
	assign data_rdata = dmem[data_req.addr[7:2]];

	always @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 64; i++) begin
				dmem[i] <= data_init[i];
			end
		end else if (data_req.en && data_req.we && !data_stall) begin
			dmem[data_req.addr[7:2]] <= data_req.wdata;
		end
	end

	// Back-pressure on about one cycle in four
	always @(negedge clk) begin
		if (!rst_n) begin
			data_stall <= 1'b0;
		end else begin
			data_stall <= ($urandom % 4) == 0;
		end
	end

	initial begin
		void'($urandom(32'h2280));
		rst_n      = 1'b0;
		data_stall = 1'b0;
		for (int i = 0; i < 64; i++) begin
			imem[i]      = '0;
			data_init[i] = $urandom();
		end
		$readmemh("bench/program.hex", imem);
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n <= 1'b1;
		wait (loop_done);
		@(negedge clk);
		$display("Errors: %0d, retired instructions: %0d", errors, retired);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired at %0t ns before the program reached its self-loop", $time);
		$display("Errors: %0d, retired instructions: %0d", errors, retired);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== bench/retire_checker.sv ====
`default_nettype none

module retire_checker
	import cpu_pkg::*;
(
	input  logic          clk,
	input  logic          rst_n_i,
	input  RetireInfo_t   retire_i,
	input  MemAccessReq_t data_req_i,
	input  logic          data_stall_i,
	input  Word_t         data_init_i [64],
	output int            errors_o,
	output int            retired_o,
	output logic          done_o
);

	timeunit 1ns;
	timeprecision 1ps;

	typedef struct packed {
		logic      we;
		RegAddr_t  waddr;
		Word_t     wdata;
		logic      store;
		Word_t     st_addr;
		Word_t     st_data;
		logic      taken;
		InstAddr_t target;
	} Expect_t;

	Word_t     prog [64];
	Word_t     model_regs [32];
	Word_t     model_mem [64];
	InstAddr_t model_pc;
	InstAddr_t model_npc;
	Word_t     store_addr_q [$];
	Word_t     store_data_q [$];
	int        loop_count;
	int        errors;
	int        retired;

	assign errors_o  = errors;
	assign retired_o = retired;
	assign done_o    = loop_count >= 2;

	initial begin
		for (int i = 0; i < 64; i++) begin
			prog[i] = '0;
		end
		$readmemh("bench/program.hex", prog);
	end

	// Runs one instruction on the model state
	function automatic Expect_t execute_model(input InstAddr_t pc);
		Word_t     word;
		Word_t     rs_val;
		Word_t     rt_val;
		Word_t     sext;
		Word_t     addr;
		InstAddr_t pc4;
		Expect_t   e;
		word    = prog[pc[7:2]];
		rs_val  = model_regs[word[25:21]];
		rt_val  = model_regs[word[20:16]];
		sext    = {{16{word[15]}}, word[15:0]};
		addr    = rs_val + sext;
		pc4     = pc + 32'd4;
		e       = '0;
		e.waddr = word[20:16];
		e.we    = 1'b1;
		case (word[31:26])
			6'h00: begin
				e.waddr = word[15:11];
				case (word[5:0])
					6'h00: e.wdata = rt_val << word[10:6];
					6'h21: e.wdata = rs_val + rt_val;
					6'h23: e.wdata = rs_val - rt_val;
					6'h24: e.wdata = rs_val & rt_val;
					6'h25: e.wdata = rs_val | rt_val;
					6'h26: e.wdata = rs_val ^ rt_val;
					6'h2a: e.wdata = {31'h0, $signed(rs_val) < $signed(rt_val)};
					default: e.we = 1'b0;
				endcase
			end
			6'h02: begin
				e.we     = 1'b0;
				e.taken  = 1'b1;
				e.target = {pc4[31:28], word[25:0], 2'b00};
			end
			6'h04, 6'h05: begin
				e.we     = 1'b0;
				e.taken  = (rs_val == rt_val) == (word[31:26] == 6'h04);
				e.target = pc4 + {sext[29:0], 2'b00};
			end
			6'h09: e.wdata = rs_val + sext;
			6'h0d: e.wdata = rs_val | {16'h0, word[15:0]};
			6'h0f: e.wdata = {word[15:0], 16'h0};
			6'h23: e.wdata = model_mem[addr[7:2]];
			6'h2b: begin
				e.we      = 1'b0;
				e.store   = 1'b1;
				e.st_addr = addr;
				e.st_data = rt_val;
				model_mem[addr[7:2]] = rt_val;
			end
			default: e.we = 1'b0;
		endcase
		// Writes to r0 are dropped
		if (e.waddr == '0) begin
			e.we = 1'b0;
		end
		if (e.we) begin
			model_regs[e.waddr] = e.wdata;
		end
		return e;
	endfunction

	task automatic compare_value(input string name, input Word_t expected, input Word_t actual);
		if (expected !== actual) begin
			$display("FAIL %0t ns %s expected %h got %h", $time, name, expected, actual);
			errors++;
		end
	endtask

	always @(posedge clk) begin : compare
		Expect_t e;
		Word_t   st_addr;
		Word_t   st_data;
		if (!rst_n_i) begin
			for (int i = 0; i < 32; i++) begin
				model_regs[i] = '0;
			end
			for (int i = 0; i < 64; i++) begin
				model_mem[i] = data_init_i[i];
			end
			model_pc   = RESET_PC;
			model_npc  = RESET_PC + 32'd4;
			loop_count = 0;
			errors     = 0;
			retired    = 0;
			store_addr_q.delete();
			store_data_q.delete();
		end else begin
			if (retire_i.valid) begin
				retired++;
				compare_value("retire_o.pc", model_pc, retire_i.pc);
				e = execute_model(model_pc);
				compare_value("retire_o.we", {31'h0, e.we}, {31'h0, retire_i.we});
				if (e.we) begin
					compare_value("retire_o.waddr", {27'h0, e.waddr}, {27'h0, retire_i.waddr});
					compare_value("retire_o.wdata", e.wdata, retire_i.wdata);
				end
				if (e.store && store_addr_q.size() == 0) begin
					$display("Error at %0t ns: store at pc %h retired without a memory write",
						$time, model_pc);
					errors++;
				end else if (e.store) begin
					st_addr = store_addr_q.pop_front();
					st_data = store_data_q.pop_front();
					compare_value("data_req_o.addr", e.st_addr, st_addr);
					compare_value("data_req_o.wdata", e.st_data, st_data);
				end else if (store_addr_q.size() != 0) begin
					$display("Error at %0t ns: memory was written but no store retired", $time);
					errors++;
					store_addr_q.delete();
					store_data_q.delete();
				end
				if (e.taken && e.target == model_pc) begin
					loop_count++;
				end
				// Delay slot runs before the target
				model_pc  = model_npc;
				model_npc = e.taken ? e.target : model_npc + 32'd4;
			end
			if (data_req_i.en && data_req_i.we && !data_stall_i) begin
				store_addr_q.push_back(data_req_i.addr);
				store_data_q.push_back(data_req_i.wdata);
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/trivial_mips.sv ====
`default_nettype none

module trivial_mips
	import cpu_pkg::*;
#(
	parameter int REG_FORWARD = 1
) (
	input  logic          clk,
	input  logic          rst_n_i,
	output InstAddr_t     inst_addr_o,
	input  Inst_t         inst_i,
	output MemAccessReq_t data_req_o,
	input  Word_t         data_rdata_i,
	input  logic          data_stall_i,
	output RetireInfo_t   retire_o
);

	// Register file
	RegAddr_t     reg_raddr1;
	RegAddr_t     reg_raddr2;
	Word_t        reg_rdata1;
	Word_t        reg_rdata2;
	RegWriteReq_t wb_wr;

	regs general_regs_instance(
		.clk,
		.rst_n_i,
		.wr_i(wb_wr),
		.raddr1_i(reg_raddr1),
		.raddr2_i(reg_raddr2),
		.rdata1_o(reg_rdata1),
		.rdata2_o(reg_rdata2)
	);

	Stall_t stall;
	logic   stall_from_id;
	logic   stall_from_mem;

	ctrl ctrl_instance(
		.stall_from_id_i(stall_from_id),
		.stall_from_mem_i(stall_from_mem),
		.stall_o(stall)
	);

	// IF
	logic      jump;
	InstAddr_t jump_to;
	InstAddr_t id_pc;
	Inst_t     id_inst;

	cpu_if stage_if(
		.clk,
		.rst_n_i,
		.stall_i(stall),
		.jump_i(jump),
		.jump_to_i(jump_to),
		.inst_addr_o,
		.inst_i,
		.id_pc_o(id_pc),
		.id_inst_o(id_inst)
	);

	// ID
	Oper_t        ex_op;
	InstAddr_t    ex_pc;
	Word_t        ex_a;
	Word_t        ex_b;
	Word_t        ex_store_data;
	RegAddr_t     ex_waddr;
	logic         ex_we;
	RegWriteReq_t ex_wr;
	logic         ex_is_load;
	RegWriteReq_t mem_fwd_wr;

	cpu_id #(
		.REG_FORWARD(REG_FORWARD)
	) stage_id(
		.clk,
		.rst_n_i,
		.stall_i(stall),
		.pc_i(id_pc),
		.inst_i(id_inst),
		.reg1_i(reg_rdata1),
		.reg2_i(reg_rdata2),
		.ex_wr_i(ex_wr),
		.ex_is_load_i(ex_is_load),
		.mem_wr_i(mem_fwd_wr),
		.reg_raddr1_o(reg_raddr1),
		.reg_raddr2_o(reg_raddr2),
		.stall_req_o(stall_from_id),
		.jump_o(jump),
		.jump_to_o(jump_to),
		.ex_op_o(ex_op),
		.ex_pc_o(ex_pc),
		.ex_a_o(ex_a),
		.ex_b_o(ex_b),
		.ex_store_data_o(ex_store_data),
		.ex_waddr_o(ex_waddr),
		.ex_we_o(ex_we)
	);

	// EX
	Oper_t         mem_op;
	InstAddr_t     mem_pc;
	RegWriteReq_t  mem_wr;
	MemAccessReq_t mem_req;

	cpu_ex stage_ex(
		.clk,
		.rst_n_i,
		.stall_i(stall),
		.op_i(ex_op),
		.pc_i(ex_pc),
		.a_i(ex_a),
		.b_i(ex_b),
		.store_data_i(ex_store_data),
		.waddr_i(ex_waddr),
		.we_i(ex_we),
		.ex_wr_o(ex_wr),
		.ex_is_load_o(ex_is_load),
		.mem_op_o(mem_op),
		.mem_pc_o(mem_pc),
		.mem_wr_o(mem_wr),
		.mem_req_o(mem_req)
	);

	// MEM
	cpu_mem stage_mem(
		.clk,
		.rst_n_i,
		.stall_i(stall),
		.op_i(mem_op),
		.pc_i(mem_pc),
		.wr_i(mem_wr),
		.req_i(mem_req),
		.data_rdata_i,
		.data_stall_i,
		.data_req_o,
		.fwd_wr_o(mem_fwd_wr),
		.stall_req_o(stall_from_mem),
		.wb_wr_o(wb_wr),
		.retire_o
	);

endmodule

`default_nettype wire

// ==== hdl/cpu_mem.sv ====
`default_nettype none

module cpu_mem
	import cpu_pkg::*;
(
	input  logic          clk,
	input  logic          rst_n_i,
	input  Stall_t        stall_i,
	input  Oper_t         op_i,
	input  InstAddr_t     pc_i,
	input  RegWriteReq_t  wr_i,
	input  MemAccessReq_t req_i,
	input  Word_t         data_rdata_i,
	input  logic          data_stall_i,
	output MemAccessReq_t data_req_o,
	output RegWriteReq_t  fwd_wr_o,
	output logic          stall_req_o,
	output RegWriteReq_t  wb_wr_o,
	output RetireInfo_t   retire_o
);

	assign data_req_o  = req_i;
	assign stall_req_o = req_i.en && data_stall_i;

	always_comb begin
		fwd_wr_o = wr_i;
		if (op_i == OP_LW) begin
			fwd_wr_o.wdata = data_rdata_i;
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			retire_o <= '0;
		end else if (stall_i.bubble_wb) begin
			retire_o.valid <= 1'b0;
			retire_o.we    <= 1'b0;
		end else begin
			retire_o.valid <= op_i != OP_NOP;
			retire_o.pc    <= pc_i;
			retire_o.we    <= fwd_wr_o.we;
			retire_o.waddr <= fwd_wr_o.waddr;
			retire_o.wdata <= fwd_wr_o.wdata;
		end
	end

	// Register file write comes straight off the WB trace
	assign wb_wr_o.we    = retire_o.we;
	assign wb_wr_o.waddr = retire_o.waddr;
	assign wb_wr_o.wdata = retire_o.wdata;

	assert property (@(posedge clk) disable iff (!rst_n_i)
		data_req_o.en |-> data_req_o.addr[1:0] == 2'b00);

	// An access stays put until the memory accepts it
	assert property (@(posedge clk) disable iff (!rst_n_i)
		stall_req_o |=> $stable(data_req_o));

endmodule

`default_nettype wire

// ==== hdl/cpu_ex.sv ====
`default_nettype none

module cpu_ex
	import cpu_pkg::*;
(
	input  logic          clk,
	input  logic          rst_n_i,
	input  Stall_t        stall_i,
	input  Oper_t         op_i,
	input  InstAddr_t     pc_i,
	input  Word_t         a_i,
	input  Word_t         b_i,
	input  Word_t         store_data_i,
	input  RegAddr_t      waddr_i,
	input  logic          we_i,
	output RegWriteReq_t  ex_wr_o,
	output logic          ex_is_load_o,
	output Oper_t         mem_op_o,
	output InstAddr_t     mem_pc_o,
	output RegWriteReq_t  mem_wr_o,
	output MemAccessReq_t mem_req_o
);

	Word_t         result;
	MemAccessReq_t req;

	always_comb begin
		case (op_i)
			OP_ADDU, OP_ADDIU, OP_LW, OP_SW: result = a_i + b_i;
			OP_SUBU: result = a_i - b_i;
			OP_AND: result = a_i & b_i;
			OP_OR, OP_ORI: result = a_i | b_i;
			OP_XOR: result = a_i ^ b_i;
			OP_SLT: result = {31'h0, $signed(a_i) < $signed(b_i)};
			OP_SLL: result = a_i << b_i[4:0];
			OP_LUI: result = b_i;
			default: result = '0;
		endcase
	end

	// Loads show only their address here and decode treats them as not ready
	assign ex_wr_o.we    = we_i;
	assign ex_wr_o.waddr = waddr_i;
	assign ex_wr_o.wdata = result;
	assign ex_is_load_o  = op_i == OP_LW;

	assign req.en    = op_i == OP_LW || op_i == OP_SW;
	assign req.we    = op_i == OP_SW;
	assign req.addr  = result;
	assign req.wdata = store_data_i;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			mem_op_o  <= OP_NOP;
			mem_wr_o  <= '0;
			mem_req_o <= '0;
		end else if (!stall_i.hold_mem) begin
			mem_op_o  <= op_i;
			mem_wr_o  <= ex_wr_o;
			mem_req_o <= req;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall_i.hold_mem) begin
			mem_pc_o <= pc_i;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/cpu_id.sv ====
`default_nettype none

module cpu_id
	import cpu_pkg::*;
#(
	parameter int REG_FORWARD = 1
) (
	input  logic         clk,
	input  logic         rst_n_i,
	input  Stall_t       stall_i,
	input  InstAddr_t    pc_i,
	input  Inst_t        inst_i,
	input  Word_t        reg1_i,
	input  Word_t        reg2_i,
	input  RegWriteReq_t ex_wr_i,
	input  logic         ex_is_load_i,
	input  RegWriteReq_t mem_wr_i,
	output RegAddr_t     reg_raddr1_o,
	output RegAddr_t     reg_raddr2_o,
	output logic         stall_req_o,
	output logic         jump_o,
	output InstAddr_t    jump_to_o,
	output Oper_t        ex_op_o,
	output InstAddr_t    ex_pc_o,
	output Word_t        ex_a_o,
	output Word_t        ex_b_o,
	output Word_t        ex_store_data_o,
	output RegAddr_t     ex_waddr_o,
	output logic         ex_we_o
);

	Oper_t     op;
	logic      use_rs;
	logic      use_rt;
	logic      we;
	RegAddr_t  waddr;
	Word_t     imm_sext;
	Word_t     rs_val;
	Word_t     rt_val;
	Word_t     a;
	Word_t     b;
	InstAddr_t pc_plus4;
	logic      ex_hit;
	logic      mem_hit;

	function automatic logic hits(input RegWriteReq_t wr, input RegAddr_t addr,
			input logic used);
		return used && wr.we && addr != '0 && wr.waddr == addr;
	endfunction

	// Newest producer first
	function automatic Word_t pick(input RegAddr_t addr, input Word_t rf_val,
			input RegWriteReq_t ex_wr, input RegWriteReq_t mem_wr);
		if (REG_FORWARD != 0 && hits(ex_wr, addr, 1'b1)) begin
			return ex_wr.wdata;
		end
		if (REG_FORWARD != 0 && hits(mem_wr, addr, 1'b1)) begin
			return mem_wr.wdata;
		end
		return rf_val;
	endfunction

	assign reg_raddr1_o = inst_i.i.rs;
	assign reg_raddr2_o = inst_i.i.rt;
	assign imm_sext     = {{16{inst_i.i.imm[15]}}, inst_i.i.imm};
	assign pc_plus4     = pc_i + 32'd4;

	always_comb begin
		op     = OP_NOP;
		use_rs = 1'b1;
		use_rt = 1'b0;
		we     = 1'b1;
		waddr  = inst_i.i.rt;
		case (inst_i.i.opcode)
			6'h00: begin
				waddr  = inst_i.r.rd;
				use_rt = 1'b1;
				case (inst_i.r.funct)
					6'h00: op = OP_SLL;
					6'h21: op = OP_ADDU;
					6'h23: op = OP_SUBU;
					6'h24: op = OP_AND;
					6'h25: op = OP_OR;
					6'h26: op = OP_XOR;
					6'h2a: op = OP_SLT;
					default: we = 1'b0;
				endcase
			end
			6'h02: op = OP_J;
			6'h04: op = OP_BEQ;
			6'h05: op = OP_BNE;
			6'h09: op = OP_ADDIU;
			6'h0d: op = OP_ORI;
			6'h0f: op = OP_LUI;
			6'h23: op = OP_LW;
			6'h2b: op = OP_SW;
			default: we = 1'b0;
		endcase
		// These never read rs, their rs bits are target or zero
		if (op inside {OP_NOP, OP_J, OP_LUI, OP_SLL}) begin
			use_rs = 1'b0;
		end
		if (op inside {OP_BEQ, OP_BNE, OP_SW}) begin
			use_rt = 1'b1;
		end
		if (op inside {OP_J, OP_BEQ, OP_BNE, OP_SW}) begin
			we = 1'b0;
		end
	end

	assign rs_val = pick(inst_i.i.rs, reg1_i, ex_wr_i, mem_wr_i);
	assign rt_val = pick(inst_i.i.rt, reg2_i, ex_wr_i, mem_wr_i);

	assign ex_hit  = hits(ex_wr_i, inst_i.i.rs, use_rs) || hits(ex_wr_i, inst_i.i.rt, use_rt);
	assign mem_hit = hits(mem_wr_i, inst_i.i.rs, use_rs) || hits(mem_wr_i, inst_i.i.rt, use_rt);
	// Without forwarding every pending producer stalls
	assign stall_req_o = REG_FORWARD != 0 ? ex_hit && ex_is_load_i : ex_hit || mem_hit;

	always_comb begin
		a = rs_val;
		b = rt_val;
		case (op)
			OP_SLL: begin
				a = rt_val;
				b = {27'h0, inst_i.r.shamt};
			end
			OP_ADDIU, OP_LW, OP_SW: b = imm_sext;
			OP_ORI: b = {16'h0, inst_i.i.imm};
			OP_LUI: b = {inst_i.i.imm, 16'h0};
			default: ;
		endcase
	end

	always_comb begin
		jump_o    = 1'b0;
		jump_to_o = pc_plus4 + {imm_sext[29:0], 2'b00};
		case (op)
			OP_BEQ: jump_o = rs_val == rt_val;
			OP_BNE: jump_o = rs_val != rt_val;
			OP_J: begin
				jump_o    = 1'b1;
				jump_to_o = {pc_plus4[31:28], inst_i.i.rs, inst_i.i.rt, inst_i.i.imm, 2'b00};
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ex_op_o <= OP_NOP;
			ex_we_o <= 1'b0;
		end else if (stall_i.bubble_ex) begin
			ex_op_o <= OP_NOP;
			ex_we_o <= 1'b0;
		end else if (!stall_i.hold_ex) begin
			ex_op_o <= op;
			// r0 targets retire as non-writing
			ex_we_o <= we && waddr != '0;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall_i.hold_ex) begin
			ex_pc_o         <= pc_i;
			ex_a_o          <= a;
			ex_b_o          <= b;
			ex_store_data_o <= rt_val;
			ex_waddr_o      <= waddr;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/cpu_if.sv ====
`default_nettype none

module cpu_if
	import cpu_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n_i,
	input  Stall_t    stall_i,
	input  logic      jump_i,
	input  InstAddr_t jump_to_i,
	output InstAddr_t inst_addr_o,
	input  Inst_t     inst_i,
	output InstAddr_t id_pc_o,
	output Inst_t     id_inst_o
);

	// Unassigned opcode that decode turns into a bubble
	localparam Inst_t INST_BUBBLE = '1;

	InstAddr_t pc_q;
	InstAddr_t pc_next;

	assign pc_next     = jump_i ? jump_to_i : pc_q + 32'd4;
	assign inst_addr_o = pc_q;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			pc_q <= RESET_PC;
		end else if (!stall_i.hold_if) begin
			pc_q <= pc_next;
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			id_inst_o <= INST_BUBBLE;
		end else if (!stall_i.hold_id) begin
			id_inst_o <= inst_i;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall_i.hold_id) begin
			id_pc_o <= pc_q;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/ctrl.sv ====
`default_nettype none

module ctrl
	import cpu_pkg::*;
(
	input  logic   stall_from_id_i,
	input  logic   stall_from_mem_i,
	output Stall_t stall_o
);

	always_comb begin
		stall_o = '0;
		if (stall_from_mem_i) begin
			// Pending data access freezes everything up to MEM
			stall_o.hold_if   = 1'b1;
			stall_o.hold_id   = 1'b1;
			stall_o.hold_ex   = 1'b1;
			stall_o.hold_mem  = 1'b1;
			stall_o.bubble_wb = 1'b1;
		end else if (stall_from_id_i) begin
			stall_o.hold_if   = 1'b1;
			stall_o.hold_id   = 1'b1;
			stall_o.bubble_ex = 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/regs.sv ====
`default_nettype none

module regs
	import cpu_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n_i,
	input  RegWriteReq_t wr_i,
	input  RegAddr_t     raddr1_i,
	input  RegAddr_t     raddr2_i,
	output Word_t        rdata1_o,
	output Word_t        rdata2_o
);

	Word_t regs_q [31:1];

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 1; i < 32; i++) begin
				regs_q[i] <= '0;
			end
		end else if (wr_i.we && wr_i.waddr != '0) begin
			regs_q[wr_i.waddr] <= wr_i.wdata;
		end
	end

	// Same-cycle write wins over the stored value
	function automatic Word_t read_port(input RegAddr_t addr);
		if (addr == '0) begin
			return '0;
		end
		if (wr_i.we && wr_i.waddr == addr) begin
			return wr_i.wdata;
		end
		return regs_q[addr];
	endfunction

	always_comb begin
		rdata1_o = read_port(raddr1_i);
		rdata2_o = read_port(raddr2_i);
	end

	assert property (@(posedge clk) disable iff (!rst_n_i)
		wr_i.we |-> !$isunknown(wr_i.wdata));

endmodule

`default_nettype wire

// ==== hdl/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

	typedef logic [31:0] Word_t;
	typedef logic [31:0] InstAddr_t;
	typedef logic [4:0]  RegAddr_t;

	typedef struct packed {
		logic [5:0] opcode;
		RegAddr_t   rs;
		RegAddr_t   rt;
		RegAddr_t   rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} InstR_t;

	typedef struct packed {
		logic [5:0]  opcode;
		RegAddr_t    rs;
		RegAddr_t    rt;
		logic [15:0] imm;
	} InstI_t;

	// One fetched word that decode reads as R-type or I-type
	typedef union packed {
		InstR_t r;
		InstI_t i;
	} Inst_t;

	// OP_NOP only ever marks a bubble
	typedef enum logic [3:0] {
		OP_NOP, OP_ADDU, OP_SUBU, OP_AND,
		OP_OR, OP_XOR, OP_SLT, OP_SLL,
		OP_ADDIU, OP_ORI, OP_LUI, OP_LW,
		OP_SW, OP_BEQ, OP_BNE, OP_J
	} Oper_t;

	typedef struct packed {
		logic     we;
		RegAddr_t waddr;
		Word_t    wdata;
	} RegWriteReq_t;

	typedef struct packed {
		logic  en;
		logic  we;
		Word_t addr;
		Word_t wdata;
	} MemAccessReq_t;

	typedef struct packed {
		logic hold_if;
		logic hold_id;
		logic hold_ex;
		logic hold_mem;
		logic bubble_ex;
		logic bubble_wb;
	} Stall_t;

	typedef struct packed {
		logic      valid;
		InstAddr_t pc;
		logic      we;
		RegAddr_t  waddr;
		Word_t     wdata;
	} RetireInfo_t;

	parameter InstAddr_t RESET_PC = 32'h0000_0000;

endpackage

`default_nettype wire
